//--- vlog.f
design/obj_pkg.sv
design/mem_pkg.sv
design/obj_table.sv
design/obj_line_table.sv
design/obj_draw.sv
design/obj_line.sv
design/cps_obj.sv
verification/obj_assertions.sv
verification/obj_checker.sv
verification/obj_tb.sv

//--- Bender.yml
package:
  name: cps_obj

sources:
  - target: design
    files:
      - design/obj_pkg.sv
      - design/mem_pkg.sv
      - design/obj_table.sv
      - design/obj_line_table.sv
      - design/obj_draw.sv
      - design/obj_line.sv
      - design/cps_obj.sv
  - target: verification
    files:
      - verification/obj_assertions.sv
      - verification/obj_checker.sv
      - verification/obj_tb.sv

//--- verification/obj_tb.sv
// testbench top that runs cps_obj through six object tables with video timing and memory models
`timescale 1ns/1ps

module obj_tb;
    localparam int N_OBJ    = 32;
    localparam int MAX_LINE = 8;
    localparam int N_TESTS  = 6;
    localparam int LINE_CLK = 1024;
    localparam int LIMIT    = N_TESTS * 2 * 262 * LINE_CLK / 10 * 11;  // plus 10%

    logic                clk, arst_n, pxl_cen, vb, start;
    obj_pkg::obj_coord_t vrender1, vdump, hdump;
    logic [15:0]         vram_base;
    mem_pkg::vram_addr_t vram_addr;
    mem_pkg::vram_word_t vram_data;
    logic                vram_ok, vram_cs;
    mem_pkg::rom_addr_t  rom_addr;
    logic                rom_half;
    mem_pkg::rom_word_t  rom_data;
    logic                rom_cs, rom_ok;
    obj_pkg::pxl_t       pxl;

    logic [15:0] img [4*N_OBJ];   // object table image in VRAM
    integer      seed = 3574;
    int          ctick = LINE_CLK - 1;
    int          line  = 261;
    int          vram_wait = 0;
    int          rom_wait  = 0;
    int          ext_errors = 0;
    int          cycles = 0;
    int          test_id = 0;
    logic        check_en = 1'b0;
    int          tests_passed, tests_failed;

    cps_obj #(.N_OBJ(N_OBJ), .MAX_LINE(MAX_LINE)) u_cps_obj (.*);

    obj_checker #(.N_OBJ(N_OBJ), .MAX_LINE(MAX_LINE)) u_checker (
        .clk(clk), .pxl_cen(pxl_cen), .vdump(vdump), .hdump(hdump), .pxl(pxl),
        .check_en(check_en), .test_id(test_id), .img(img),
        .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // VRAM model with random latency 1..8
    always @(posedge clk) begin
        #2;
        vram_ok = 1'b0;
        if (vram_cs) begin
            if (vram_wait == 0)
                vram_wait = 1 + {$random(seed)} % 8;
            vram_wait = vram_wait - 1;
            if (vram_wait == 0) begin
                vram_ok = 1'b1;
                if (vram_addr - {vram_base, 8'h00} >= 4 * N_OBJ) begin
                    $display("VRAM read outside the object table at address %h", vram_addr);
                    ext_errors++;
                    vram_data = 16'hFF00;
                end else begin
                    vram_data = img[vram_addr - {vram_base, 8'h00}];
                end
            end
        end
    end

    // graphics ROM model returning a hash of address and half
    always @(posedge clk) begin
        #2;
        rom_ok = 1'b0;
        if (rom_cs) begin
            if (rom_wait == 0)
                rom_wait = 1 + {$random(seed)} % 8;
            rom_wait = rom_wait - 1;
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = u_checker.rom_hash(rom_addr, rom_half);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not end within %0d cycles", LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // one clock of video timing
    task automatic tick();
        @(posedge clk);
        #2;
        ctick = (ctick + 1) % LINE_CLK;
        if (ctick == 0)
            line = (line + 1) % 262;
        hdump    = 9'(ctick / 2);
        pxl_cen  = ctick[0];      // second clock of each hdump value
        start    = ctick == 0;
        vdump    = 9'(line);
        vrender1 = 9'((line + 2) % 262);
        vb       = line >= 240;
    endtask

    task automatic run_frame();
        repeat (262 * LINE_CLK) tick();
    endtask

    function automatic logic [15:0] attr_word(input int pal, input bit fx, input bit fy);
        return {9'd0, fy, fx, 5'(pal)};
    endfunction

    task automatic put_obj(input int i, input int x, input int y, input int code,
                           input logic [15:0] attr);
        img[4*i]   = 16'(x) & 16'h01FF;
        img[4*i+1] = 16'(y) & 16'h01FF;
        img[4*i+2] = 16'(code);
        img[4*i+3] = attr;
    endtask

    task automatic end_table(input int i);
        img[4*i+3] = {obj_pkg::END_MARK, 8'h00};
    endtask

    task automatic build_table(input int t);
        for (int i = 0; i < 4 * N_OBJ; i++)
            img[i] = '0;
        vram_base = 16'h0000;
        case (t)
            1: end_table(0);                   // empty frame
            2: begin
                put_obj(0, 100, 50, 16'h0012, attr_word(3, 0, 0));
                put_obj(1, 505, 120, 16'h0013, attr_word(7, 0, 0));  // wraps to x 0
                put_obj(2, 30, 508, 16'h0014, attr_word(12, 0, 0));  // wraps over line 0
                put_obj(3, 200, 230, 16'h0015, attr_word(30, 0, 0));
                end_table(4);
            end
            3: begin
                put_obj(0, 40, 60, 16'h0040, attr_word(4, 0, 0));
                put_obj(1, 80, 60, 16'h0040, attr_word(5, 1, 0));
                put_obj(2, 120, 60, 16'h0040, attr_word(6, 0, 1));
                put_obj(3, 160, 60, 16'h0040, attr_word(8, 1, 1));
                end_table(4);
            end
            4: begin
                put_obj(0, 300, 100, 16'h0077, attr_word(1, 0, 0));
                put_obj(1, 308, 104, 16'h0078, attr_word(2, 0, 0));  // on top
                end_table(2);
            end
            5: begin
                for (int i = 0; i < 12; i++)
                    put_obj(i, 20 * i, 150, 16'h0100 + i, attr_word(i, 0, 0));
                end_table(12);
            end
            default: begin
                vram_base = 16'h0123;
                for (int i = 0; i < N_OBJ; i++)
                    put_obj(i, $random(seed), $random(seed), $random(seed),
                            16'($random(seed)) & 16'h007F);
            end
        endcase
    endtask

    initial begin
        arst_n = 1'b0;
        pxl_cen = 1'b0;
        vb = 1'b0;
        start = 1'b0;
        vrender1 = '0;
        vdump = '0;
        hdump = '0;
        vram_base = '0;
        vram_data = '0;
        vram_ok = 1'b0;
        rom_data = '0;
        rom_ok = 1'b0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int t = 1; t <= N_TESTS; t++) begin
            build_table(t);
            check_en = 1'b0;
            run_frame();           // table copied in this vblank
            test_id  = t;
            check_en = 1'b1;
            run_frame();
            if (t == N_TESTS)
                run_frame();       // random table gets a second frame
        end
        check_en = 1'b0;
        repeat (2) @(posedge clk);
        $display("tests ok: %0d, tests failed: %0d, bus errors: %0d, assertions: %0d",
                 tests_passed, tests_failed, ext_errors, u_cps_obj.u_assertions.fail_cnt);
        if (tests_failed == 0 && ext_errors == 0 && u_cps_obj.u_assertions.fail_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- verification/obj_checker.sv
// watches the object layer output and compares each visible pixel with a reference screen model
`timescale 1ns/1ps

module obj_checker #(
    parameter int N_OBJ    = 32,
    parameter int MAX_LINE = 8
) (
    input  logic                clk,
    input  logic                pxl_cen,
    input  obj_pkg::obj_coord_t vdump,
    input  obj_pkg::obj_coord_t hdump,
    input  obj_pkg::pxl_t       pxl,
    input  logic                check_en,
    input  int                  test_id,
    input  logic [15:0]         img [4*N_OBJ],
    output int                  tests_passed,
    output int                  tests_failed
);
    int   errs = 0;
    int   checked = 0;
    logic pend = 1'b0;
    logic en_q = 1'b0;
    int   pv, ph;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "empty_table";
            2: return "single_objects";
            3: return "flips";
            4: return "overlap";
            5: return "line_limit";
            default: return "random_table";
        endcase
    endfunction

    // ROM contents, shared with the ROM model
    function automatic logic [31:0] rom_hash(input logic [19:0] addr, input logic half);
        logic [31:0] k;
        k = {11'd0, addr, half} * 32'h9E3779B1;
        return k ^ (k >> 15);
    endfunction

    // expected pixel of line v, column h
    function automatic logic [8:0] ref_pixel(input int v, input int h);
        logic [8:0]  res, dy, col;
        logic [15:0] attr;
        logic [3:0]  row, tcol, nib;
        logic [31:0] word;
        int          cnt;
        res = obj_pkg::BLANK_PXL;
        cnt = 0;
        for (int i = 0; i < N_OBJ; i++) begin
            attr = img[4*i+3];
            if (attr[15:8] == obj_pkg::END_MARK)
                break;
            dy = 9'(v) - img[4*i+1][8:0];
            if (dy < 16 && cnt < MAX_LINE) begin
                cnt++;                              // line slot used even if off column
                col = 9'(h) - img[4*i][8:0];
                if (col < 16) begin
                    row  = attr[6] ? ~dy[3:0] : dy[3:0];
                    tcol = attr[5] ? ~col[3:0] : col[3:0];
                    word = rom_hash({img[4*i+2], row}, tcol[3]);
                    nib  = word[31 - 4 * tcol[2:0] -: 4];
                    if (nib != 4'hF)
                        res = {attr[4:0], nib};     // later entry on top
                end
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (check_en && pxl_cen && vdump < 240) begin
            pv   = vdump;
            ph   = hdump;
            pend = 1'b1;
        end
        if (en_q && !check_en) begin
            if (checked == 0) begin
                $display("test %0d %s: no pixels were checked", test_id, test_name(test_id));
                tests_failed++;
            end else if (errs == 0) begin
                $display("test %0d %s: ok, %0d pixels", test_id, test_name(test_id), checked);
                tests_passed++;
            end else begin
                $display("test %0d %s: %0d wrong pixels", test_id, test_name(test_id), errs);
                tests_failed++;
            end
            errs    = 0;
            checked = 0;
        end
        en_q = check_en;
    end

    // pxl settles on the edge after the pxl_cen cycle
    always @(negedge clk) begin
        logic [8:0] exp_pxl;
        if (pend) begin
            pend    = 1'b0;
            exp_pxl = ref_pixel(pv, ph);
            checked++;
            if (pxl !== exp_pxl) begin
                errs++;
                if (errs <= 5)
                    $display("MISMATCH %s line %0d col %0d expected %h actual %h",
                             test_name(test_id), pv, ph, exp_pxl, pxl);
            end
        end
    end

endmodule

//--- verification/obj_assertions.sv
// bus protocol and line buffer write assertions bound into cps_obj
`timescale 1ns/1ps

module obj_assertions (
    input logic                clk,
    input logic                arst_n,
    input logic                vb,
    input logic                vram_cs,
    input logic                vram_ok,
    input mem_pkg::vram_addr_t vram_addr,
    input logic                rom_cs,
    input logic                rom_ok,
    input mem_pkg::rom_addr_t  rom_addr,
    input logic                rom_half,
    input logic                buf_wr,
    input obj_pkg::pxl_t       buf_data
);
    int fail_cnt = 0;  // failed assertions so far

    // request held while the memory stalls
    a_vram_hold: assert property (@(posedge clk) disable iff (!arst_n)
        vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr))
        else begin
            fail_cnt++;
            $error("vram request changed while waiting");
        end

    a_rom_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr) && $stable(rom_half))
        else begin
            fail_cnt++;
            $error("rom request changed while waiting");
        end

    a_vram_start: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(vram_cs) |-> $past($rose(vb)))
        else begin
            fail_cnt++;
            $error("vram copy began without a vblank edge");
        end

    a_no_clear: assert property (@(posedge clk) disable iff (!arst_n)
        buf_wr |-> buf_data[3:0] != obj_pkg::TRANSPARENT)
        else begin
            fail_cnt++;
            $error("transparent pixel written to the line buffer");
        end

endmodule

bind cps_obj obj_assertions u_assertions (
    .clk(clk), .arst_n(arst_n), .vb(vb),
    .vram_cs(vram_cs), .vram_ok(vram_ok), .vram_addr(vram_addr),
    .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_addr(rom_addr), .rom_half(rom_half),
    .buf_wr(buf_wr), .buf_data(buf_data)
);

//--- design/cps_obj.sv
// object layer top, wires table copy, line selection, drawing and line buffer together
`timescale 1ns/1ps

module cps_obj #(
    parameter int N_OBJ    = 32,   // table entries, up to 64
    parameter int MAX_LINE = 8     // objects drawn per line
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                vb,
    input  logic                start,
    input  obj_pkg::obj_coord_t vrender1,  // two lines ahead of vdump
    input  obj_pkg::obj_coord_t vdump,
    input  obj_pkg::obj_coord_t hdump,
    input  logic [15:0]         vram_base,
    output mem_pkg::vram_addr_t vram_addr,
    input  mem_pkg::vram_word_t vram_data,
    input  logic                vram_ok,
    output logic                vram_cs,
    output mem_pkg::rom_addr_t  rom_addr,
    output logic                rom_half,
    input  mem_pkg::rom_word_t  rom_data,
    output logic                rom_cs,
    input  logic                rom_ok,
    output obj_pkg::pxl_t       pxl
);
    localparam int AW  = $clog2(4 * N_OBJ);
    localparam int LAW = $clog2(3 * MAX_LINE + 1);

    logic [AW-1:0]       frame_addr;
    mem_pkg::vram_word_t frame_data;
    logic [AW-1:0]       frame_len;
    logic [LAW-1:0]      line_addr;
    logic [15:0]         line_data;
    obj_pkg::obj_coord_t buf_addr;
    obj_pkg::pxl_t       buf_data;
    logic                buf_wr;

    obj_table #(.N_OBJ(N_OBJ)) u_table (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .vb         ( vb         ),
        .vram_base  ( vram_base  ),
        .vram_addr  ( vram_addr  ),
        .vram_data  ( vram_data  ),
        .vram_ok    ( vram_ok    ),
        .vram_cs    ( vram_cs    ),
        .frame_addr ( frame_addr ),
        .frame_data ( frame_data ),
        .frame_len  ( frame_len  )
    );

    obj_line_table #(.N_OBJ(N_OBJ), .MAX_LINE(MAX_LINE)) u_line_table (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .start      ( start      ),
        .vrender1   ( vrender1   ),
        .frame_len  ( frame_len  ),
        .frame_addr ( frame_addr ),
        .frame_data ( frame_data ),
        .line_addr  ( line_addr  ),
        .line_data  ( line_data  )
    );

    obj_draw #(.MAX_LINE(MAX_LINE)) u_draw (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .start      ( start      ),
        .line_addr  ( line_addr  ),
        .line_data  ( line_data  ),
        .rom_addr   ( rom_addr   ),
        .rom_half   ( rom_half   ),
        .rom_data   ( rom_data   ),
        .rom_cs     ( rom_cs     ),
        .rom_ok     ( rom_ok     ),
        .buf_addr   ( buf_addr   ),
        .buf_data   ( buf_data   ),
        .buf_wr     ( buf_wr     )
    );

    obj_line u_line (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .vdump_lsb  ( vdump[0]   ),  // parity picks the shown bank
        .hdump      ( hdump      ),
        .buf_addr   ( buf_addr   ),
        .buf_data   ( buf_data   ),
        .buf_wr     ( buf_wr     ),
        .pxl        ( pxl        )
    );

endmodule

//--- design/obj_line.sv
// double line buffer for objects, read against hdump and cleared behind the read
`timescale 1ns/1ps

module obj_line (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                vdump_lsb,
    input  obj_pkg::obj_coord_t hdump,
    input  obj_pkg::obj_coord_t buf_addr,
    input  obj_pkg::pxl_t       buf_data,
    input  logic                buf_wr,
    output obj_pkg::pxl_t       pxl
);
    obj_pkg::pxl_t rd_data [2];

    // bank vdump_lsb is shown, the other one is drawn
    for (genvar b = 0; b < 2; b++) begin : g_bank
        obj_pkg::pxl_t mem [512];

        assign rd_data[b] = mem[hdump];

        always_ff @(posedge clk) begin
            if (vdump_lsb == 1'(b)) begin
                if (pxl_cen)
                    mem[hdump] <= obj_pkg::BLANK_PXL;  // ready for the next draw
            end else if (buf_wr) begin
                mem[buf_addr] <= buf_data;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pxl <= obj_pkg::BLANK_PXL;
        else if (pxl_cen)
            pxl <= rd_data[vdump_lsb];  // old value, the clear lands on the same edge
    end

endmodule

//--- design/obj_draw.sv
// object drawing FSM: reads the line list, fetches ROM rows and paints the line buffer
`timescale 1ns/1ps

module obj_draw #(
    parameter int  MAX_LINE = 8,
    localparam int LAW      = $clog2(3 * MAX_LINE + 1)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    output logic [LAW-1:0]      line_addr,
    input  logic [15:0]         line_data,
    output mem_pkg::rom_addr_t  rom_addr,
    output logic                rom_half,
    input  mem_pkg::rom_word_t  rom_data,
    output logic                rom_cs,
    input  logic                rom_ok,
    output obj_pkg::obj_coord_t buf_addr,
    output obj_pkg::pxl_t       buf_data,
    output logic                buf_wr
);
    localparam int CW = $clog2(MAX_LINE + 1);

    typedef enum logic [2:0] {
        IDLE,
        RD_CNT,
        RD_OBJ,
        FETCH,
        PAINT
    } state_t;

    state_t              st;
    logic [1:0]          step;     // list read phase
    logic [CW-1:0]       n_obj;
    logic [CW-1:0]       obj_idx;
    logic                half_q;   // screen half being drawn
    logic [2:0]          pcnt;     // pixel within the ROM word
    obj_pkg::obj_coord_t x_q;
    obj_pkg::pal_t       pal_q;
    logic                flip_q;
    obj_pkg::obj_row_t   row_q;
    obj_pkg::obj_code_t  code_q;
    mem_pkg::rom_word_t  pix_q;
    logic [2:0]          nib_idx;
    obj_pkg::colour_t    nib;

    assign rom_cs   = st == FETCH;
    assign rom_addr = {code_q, row_q};
    assign rom_half = half_q ^ flip_q;      // flip x fetches the right half first
    assign nib_idx  = flip_q ? pcnt : ~pcnt;  // pixel 0 sits in the top nibble
    assign nib      = pix_q[{nib_idx, 2'b00} +: 4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st        <= IDLE;
            step      <= '0;
            line_addr <= '0;
            n_obj     <= '0;
            obj_idx   <= '0;
            half_q    <= 1'b0;
            pcnt      <= '0;
            buf_wr    <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            if (start) begin
                st        <= RD_CNT;
                step      <= '0;
                line_addr <= '0;  // object count
            end else begin
                case (st)
                    RD_CNT: begin
                        if (step == 2'd0) begin
                            step <= 2'd1;  // count arrives next clock
                        end else begin
                            step      <= '0;
                            n_obj     <= line_data[CW-1:0];
                            obj_idx   <= '0;
                            line_addr <= LAW'(1);
                            st        <= line_data[CW-1:0] == '0 ? IDLE : RD_OBJ;
                        end
                    end
                    RD_OBJ: begin
                        step <= step + 1'b1;
                        if (step != 2'd3) begin
                            line_addr <= line_addr + 1'b1;  // ends on the next slot
                        end else begin
                            half_q <= 1'b0;
                            st     <= FETCH;
                        end
                    end
                    FETCH: begin
                        if (rom_ok) begin
                            pcnt <= '0;
                            st   <= PAINT;
                        end
                    end
                    PAINT: begin
                        buf_wr <= nib != obj_pkg::TRANSPARENT;
                        pcnt   <= pcnt + 1'b1;
                        if (pcnt == 3'd7) begin
                            if (!half_q) begin
                                half_q <= 1'b1;
                                st     <= FETCH;
                            end else if (obj_idx + 1'b1 == n_obj) begin
                                st <= IDLE;    // line done
                            end else begin
                                obj_idx <= obj_idx + 1'b1;
                                step    <= '0;
                                st      <= RD_OBJ;
                            end
                        end
                    end
                    default: st <= IDLE;
                endcase
            end
        end
    end

    // object fields, list word 1 is {flip x, pal, row}
    always_ff @(posedge clk) begin
        if (st == RD_OBJ) begin
            case (step)
                2'd1: x_q <= line_data[8:0];
                2'd2: begin
                    row_q  <= line_data[3:0];
                    pal_q  <= line_data[8:4];
                    flip_q <= line_data[9];
                end
                2'd3: code_q <= line_data;
                default: ;
            endcase
        end
        if (rom_cs && rom_ok)
            pix_q <= rom_data;
        buf_addr <= x_q + obj_pkg::obj_coord_t'({half_q, pcnt});  // wraps at 512
        buf_data <= {pal_q, nib};
    end

endmodule

//--- design/obj_line_table.sv
// picks the objects that cross vrender1 and writes them into a double line list, part of cps_obj
`timescale 1ns/1ps

module obj_line_table #(
    parameter int  N_OBJ    = 32,
    parameter int  MAX_LINE = 8,
    localparam int AW       = $clog2(4 * N_OBJ),
    localparam int LAW      = $clog2(3 * MAX_LINE + 1)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  obj_pkg::obj_coord_t vrender1,
    input  logic [AW-1:0]       frame_len,
    output logic [AW-1:0]       frame_addr,
    input  mem_pkg::vram_word_t frame_data,
    input  logic [LAW-1:0]      line_addr,
    output logic [15:0]         line_data
);
    localparam int DEPTH = 3 * MAX_LINE + 1;     // word 0 is the count, kept in cnt
    localparam int CW    = $clog2(MAX_LINE + 1);
    localparam int EW    = AW - 2;

    logic [15:0]         list_ram [2][DEPTH];
    logic [CW-1:0]       cnt [2];             // objects per bank
    logic                bank;                // bank being filled
    logic                scanning;
    logic [EW-1:0]       ent;
    logic [1:0]          wrd;
    logic                rd_vld;              // frame_data is valid
    logic [1:0]          rd_wrd;              // word index of frame_data
    logic                hit;
    obj_pkg::obj_row_t   row;
    obj_pkg::obj_coord_t dy;
    logic                full;
    logic                wr_en;
    logic [1:0]          wr_off;
    logic [15:0]         wr_word;
    logic [LAW-1:0]      wr_addr;

    assign frame_addr = {ent, wrd};
    assign dy         = vrender1 - frame_data[8:0];  // mod 512
    assign full       = cnt[bank] == CW'(MAX_LINE);
    assign wr_en      = rd_vld && !full && rd_wrd != 2'd1;  // y word is not stored

    // x goes to slot word 0, code to word 2, {flip x, pal, row} to word 1
    always_comb begin
        wr_off  = 2'd0;
        wr_word = {7'd0, frame_data[8:0]};
        case (rd_wrd)
            2'd2: begin
                wr_off  = 2'd2;
                wr_word = frame_data;
            end
            2'd3: begin
                wr_off  = 2'd1;
                wr_word = {6'd0, frame_data[5], frame_data[4:0], row ^ {4{frame_data[6]}}};
            end
            default: ;
        endcase
    end

    assign wr_addr = LAW'(1 + 3 * int'(cnt[bank]) + int'(wr_off));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank     <= 1'b0;
            cnt      <= '{default: '0};
            scanning <= 1'b0;
            ent      <= '0;
            wrd      <= '0;
            rd_vld   <= 1'b0;
            rd_wrd   <= '0;
            hit      <= 1'b0;
            row      <= '0;
        end else begin
            rd_vld <= scanning;
            rd_wrd <= wrd;
            if (start) begin
                bank      <= ~bank;             // drawer now reads the old one
                cnt[~bank] <= '0;
                scanning  <= frame_len != '0;
                ent       <= '0;
                wrd       <= '0;
            end else if (scanning) begin
                wrd <= wrd + 1'b1;
                if (wrd == 2'd3) begin
                    ent <= ent + 1'b1;
                    if ({2'b00, ent} + 1'b1 == frame_len)
                        scanning <= 1'b0;       // last entry read
                end
            end
            if (rd_vld && rd_wrd == 2'd1) begin
                hit <= dy < obj_pkg::OBJ_SIZE;
                row <= dy[3:0];
            end
            if (wr_en && rd_wrd == 2'd3 && hit)
                cnt[bank] <= cnt[bank] + 1'b1;  // keep slot, else it gets overwritten
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            list_ram[bank][wr_addr] <= wr_word;
        line_data <= line_addr == '0 ? 16'(cnt[~bank]) : list_ram[~bank][line_addr];
    end

endmodule

//--- design/obj_table.sv
// copies the object table out of VRAM at the start of vertical blank, part of cps_obj
`timescale 1ns/1ps

module obj_table #(
    parameter int  N_OBJ = 32,
    localparam int AW    = $clog2(4 * N_OBJ)
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                vb,
    input  logic [15:0]         vram_base,
    output mem_pkg::vram_addr_t vram_addr,
    input  mem_pkg::vram_word_t vram_data,
    input  logic                vram_ok,
    output logic                vram_cs,
    input  logic [AW-1:0]       frame_addr,
    output mem_pkg::vram_word_t frame_data,
    output logic [AW-1:0]       frame_len
);
    localparam int WORDS = 4 * N_OBJ;

    mem_pkg::vram_word_t table_ram [WORDS];  // four words per entry
    logic [AW-1:0]       wcnt;               // word index inside the table
    logic                vb_l;
    logic                take;               // word consumed this clock
    logic                end_mark;
    logic                last_word;

    assign take      = vram_cs & vram_ok;
    assign end_mark  = wcnt[1:0] == 2'd3 && vram_data[15:8] == obj_pkg::END_MARK;  // attr word
    assign last_word = wcnt == AW'(WORDS - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vb_l      <= 1'b0;
            vram_cs   <= 1'b0;
            wcnt      <= '0;
            frame_len <= '0;
        end else begin
            vb_l <= vb;
            if (vb && !vb_l) begin  // blanking just began
                vram_cs <= 1'b1;
                wcnt    <= '0;
            end else if (take) begin
                wcnt <= wcnt + 1'b1;
                if (end_mark || last_word) begin
                    vram_cs   <= 1'b0;
                    frame_len <= end_mark ? AW'(wcnt[AW-1:2]) : AW'(N_OBJ);  // entry index
                end
            end
        end
    end

    // address counter, loaded from the base at the edge of vb
    always_ff @(posedge clk) begin
        if (vb && !vb_l)
            vram_addr <= mem_pkg::vram_addr_t'({vram_base, 8'h00});
        else if (take)
            vram_addr <= vram_addr + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (take)
            table_ram[wcnt] <= vram_data;   // marker word lands too, harmless
        frame_data <= table_ram[frame_addr];  // one clock read latency
    end

endmodule

//--- design/mem_pkg.sv
// address and data types of the VRAM and graphics ROM buses seen by the object layer
package mem_pkg;

    // VRAM, 16-bit words
    typedef logic [22:0] vram_addr_t;  // word address
    typedef logic [15:0] vram_word_t;

    // graphics ROM, address is {code, row}
    typedef logic [19:0] rom_addr_t;

    // eight 4-bit pixels per word
    // pixel 0 sits in bits 31:28
    typedef logic [31:0] rom_word_t;

    // rom_half 0 gives pixels 0..7 of a row
    // rom_half 1 gives pixels 8..15

endpackage

//--- design/obj_pkg.sv
// object geometry types and sprite constants, used by the object layer blocks
package obj_pkg;

    typedef logic [8:0]  obj_coord_t;  // screen x or y, wraps at 512
    typedef logic [15:0] obj_code_t;   // tile code
    typedef logic [4:0]  pal_t;
    typedef logic [3:0]  colour_t;     // colour index inside a tile
    typedef logic [8:0]  pxl_t;        // {palette, colour}
    typedef logic [3:0]  obj_row_t;    // row inside a sprite

    // sprites are square
    localparam int OBJ_SIZE = 16;

    localparam colour_t TRANSPARENT = 4'hF;  // never written to the line buffer
    localparam pxl_t    BLANK_PXL   = 9'h1FF;

    // attr high byte that closes the object table
    localparam logic [7:0] END_MARK = 8'hFF;

    // attr word layout
    //   [4:0] palette
    //   [5]   flip x
    //   [6]   flip y

endpackage
